/* tiny_backend_pkg.sv */
// Shared definitions for the tiny load/store back end
// Operation kinds, field widths and the register index type

package tiny_backend_pkg;

    // --------------------------------------------------
    // Field widths
    // --------------------------------------------------

    // Datapath width
    localparam int unsigned DATA_W = 32;

    // Raw immediate width before sign extension
    localparam int unsigned IMM_W = 12;

    // Register file geometry
    localparam int unsigned REG_IDX_W = 5;
    localparam int unsigned NUM_REGS  = 32;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------

    // Register index, entry 0 is the zero register
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Decoded operation kind
    // Encoding 3 is reserved and flows through as a bubble
    typedef enum logic [1:0] {
        OP_ADDI  = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2,
        OP_RSVD  = 2'd3
    } op_kind_t;

    // Forward select encoding, one bit per source
    // 2'b00 picks the register file
    localparam logic [1:0] FWD_RF  = 2'b00;
    localparam logic [1:0] FWD_MEM = 2'b01;
    localparam logic [1:0] FWD_WB  = 2'b10;

endpackage

/* regfile.sv */
// 32-entry register file, two combinational reads and one write
// Register 0 is hardwired to zero

`timescale 1ns/1ps

module regfile
    import tiny_backend_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  reg_idx_t          raddr1,
    input  reg_idx_t          raddr2,
    output logic [DATA_W-1:0] rdata1,
    output logic [DATA_W-1:0] rdata2,
    input  logic              we,
    input  reg_idx_t          waddr,
    input  logic [DATA_W-1:0] wdata
);

    // Storage for registers 1 to 31 only
    logic [DATA_W-1:0] regs [1:NUM_REGS-1];

    // Write port, index 0 dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Read ports
    // No write bypass here, WB forwarding covers the same-cycle case
    always_comb begin
        rdata1 = '0;
        rdata2 = '0;
        if (raddr1 != '0) begin
            rdata1 = regs[raddr1];
        end
        if (raddr2 != '0) begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

/* pipe_ctrl.sv */
// Pipeline control for the EX/MEM/WB back end
// Allowin chain, load-use interlock and forwarding selects

`timescale 1ns/1ps

module pipe_ctrl
    import tiny_backend_pkg::*;
(
    input  logic       in_valid,
    input  logic       ex_valid,
    input  op_kind_t   ex_kind,
    input  reg_idx_t   ex_rs1,
    input  reg_idx_t   ex_rs2,
    input  logic       mem_valid,
    input  op_kind_t   mem_kind,
    input  reg_idx_t   mem_rd,
    input  logic       wb_valid,
    input  logic       wb_we,
    input  reg_idx_t   wb_rd,
    output logic       in_allowin,
    output logic       ex_allowin,
    output logic       ex_ready_go,
    output logic       mem_allowin,
    output logic       wb_allowin,
    output logic [1:0] fwd_sel1,
    output logic [1:0] fwd_sel2
);

    // --------------------------------------------------
    // Hazard detection
    // --------------------------------------------------

    logic ex_reads1;
    logic ex_reads2;
    logic mem_hit1;
    logic mem_hit2;
    logic wb_hit1;
    logic wb_hit2;
    logic stall;

    // Which sources the EX operation actually consumes
    assign ex_reads1 = (ex_kind == OP_ADDI) || (ex_kind == OP_LOAD) ||
                       (ex_kind == OP_STORE);
    assign ex_reads2 = (ex_kind == OP_STORE);

    // MEM destination matches, register 0 never matches
    assign mem_hit1 = mem_valid && (mem_rd != '0) && (mem_rd == ex_rs1) && ex_reads1;
    assign mem_hit2 = mem_valid && (mem_rd != '0) && (mem_rd == ex_rs2) && ex_reads2;

    // WB destination matches, wb_we is already qualified by WB valid
    assign wb_hit1 = wb_valid && wb_we && (wb_rd != '0) && (wb_rd == ex_rs1);
    assign wb_hit2 = wb_valid && wb_we && (wb_rd != '0) && (wb_rd == ex_rs2);

    // Load data only exists in WB, so a load in MEM blocks its consumer
    assign stall = ex_valid && (mem_kind == OP_LOAD) && (mem_hit1 || mem_hit2);

    // Priority MEM (addi result only), then WB, then register file
    always_comb begin
        fwd_sel1 = FWD_RF;
        fwd_sel2 = FWD_RF;
        if (mem_hit1 && (mem_kind == OP_ADDI)) begin
            fwd_sel1 = FWD_MEM;
        end else if (wb_hit1) begin
            fwd_sel1 = FWD_WB;
        end
        if (mem_hit2 && (mem_kind == OP_ADDI)) begin
            fwd_sel2 = FWD_MEM;
        end else if (wb_hit2) begin
            fwd_sel2 = FWD_WB;
        end
    end

    // --------------------------------------------------
    // Allowin chain
    // --------------------------------------------------

    // MEM and WB never hold
    assign wb_allowin  = !wb_valid || 1'b1;
    assign mem_allowin = !mem_valid || wb_allowin;
    assign ex_ready_go = !stall;
    assign ex_allowin  = !ex_valid || (ex_ready_go && mem_allowin);
    assign in_allowin  = ex_allowin;

    // Checks on the hazard decisions
    always_comb begin
        assert final (!stall || (mem_valid && mem_kind == OP_LOAD))
            else $error("stall without a load in MEM");
        assert final ($onehot0(fwd_sel1) && $onehot0(fwd_sel2))
            else $error("forward select not one-hot");
        // No new operation may slip into EX under the interlock
        assert final (!(stall && in_valid && in_allowin))
            else $error("acceptance during load-use stall");
    end

endmodule

/* exe_stage.sv */
// EX stage: stage register, operand forwarding, address/result adder
// Also drives the data memory request as the operation leaves EX

`timescale 1ns/1ps

module exe_stage
    import tiny_backend_pkg::*;
#(
    parameter int unsigned ADDR_W = 10
) (
    input  logic              clk,
    input  logic              reset,
    // Upstream handshake and operation fields
    input  logic              in_valid,
    input  op_kind_t          in_kind,
    input  reg_idx_t          in_rd,
    input  reg_idx_t          in_rs1,
    input  reg_idx_t          in_rs2,
    input  logic [IMM_W-1:0]  in_imm,
    // From control
    input  logic              ex_allowin,
    input  logic              ex_ready_go,
    input  logic              mem_allowin,
    input  logic [1:0]        fwd_sel1,
    input  logic [1:0]        fwd_sel2,
    // Operand sources
    input  logic [DATA_W-1:0] rf_rdata1,
    input  logic [DATA_W-1:0] rf_rdata2,
    input  logic [DATA_W-1:0] mem_fwd_data,
    input  logic [DATA_W-1:0] wb_fwd_data,
    // Stage state seen by control and the register file
    output logic              ex_valid,
    output op_kind_t          ex_kind,
    output reg_idx_t          ex_rs1,
    output reg_idx_t          ex_rs2,
    // To MEM
    output logic              ex_to_mem_valid,
    output op_kind_t          ex_to_mem_kind,
    output reg_idx_t          ex_to_mem_rd,
    output logic [DATA_W-1:0] ex_to_mem_result,
    // Data memory request
    output logic              dmem_en,
    output logic              dmem_we,
    output logic [ADDR_W-1:0] dmem_addr,
    output logic [DATA_W-1:0] dmem_wdata
);

    // --------------------------------------------------
    // Stage register
    // --------------------------------------------------

    reg_idx_t          ex_rd;
    logic [IMM_W-1:0]  ex_imm;
    logic [DATA_W-1:0] src1;
    logic [DATA_W-1:0] src2;
    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] sum;
    logic              ex_leave;

    // Valid clears when MEM takes the item and nothing new arrives
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else if (ex_allowin) begin
            ex_valid <= in_valid;
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (in_valid && ex_allowin) begin
            ex_kind <= in_kind;
            ex_rd   <= in_rd;
            ex_rs1  <= in_rs1;
            ex_rs2  <= in_rs2;
            ex_imm  <= in_imm;
        end
    end

    // --------------------------------------------------
    // Operands and adder
    // --------------------------------------------------

    // Forwarding muxes
    assign src1 = fwd_sel1[0] ? mem_fwd_data :
                  fwd_sel1[1] ? wb_fwd_data  : rf_rdata1;
    assign src2 = fwd_sel2[0] ? mem_fwd_data :
                  fwd_sel2[1] ? wb_fwd_data  : rf_rdata2;

    // Sign-extended immediate
    assign imm_ext = {{(DATA_W-IMM_W){ex_imm[IMM_W-1]}}, ex_imm};

    // Shared by addi result and memory byte address
    assign sum = src1 + imm_ext;

    // To MEM
    assign ex_to_mem_valid  = ex_valid && ex_ready_go;
    assign ex_to_mem_kind   = ex_kind;
    assign ex_to_mem_rd     = ex_rd;
    assign ex_to_mem_result = sum;

    // Request only on the cycle the operation moves on
    assign ex_leave   = ex_valid && ex_ready_go && mem_allowin;
    assign dmem_en    = ex_leave && ((ex_kind == OP_LOAD) || (ex_kind == OP_STORE));
    assign dmem_we    = ex_leave && (ex_kind == OP_STORE);
    // Word address from the byte sum
    assign dmem_addr  = sum[ADDR_W+1:2];
    assign dmem_wdata = src2;

    // Store strobe must coincide with control releasing EX
    // otherwise the same store would be written again
    assert property (@(posedge clk) disable iff (reset)
        dmem_we |-> ex_valid && ex_allowin)
        else $error("dmem_we while EX is not released");

endmodule

/* mem_stage.sv */
// MEM stage: registers the EX result
// Picks load return data or adder result for WB

`timescale 1ns/1ps

module mem_stage
    import tiny_backend_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              ex_to_mem_valid,
    input  op_kind_t          ex_to_mem_kind,
    input  reg_idx_t          ex_to_mem_rd,
    input  logic [DATA_W-1:0] ex_to_mem_result,
    input  logic              mem_allowin,
    input  logic [DATA_W-1:0] dmem_rdata,
    output logic              mem_valid,
    output op_kind_t          mem_kind,
    output reg_idx_t          mem_rd,
    output logic [DATA_W-1:0] mem_fwd_data,
    output logic              mem_to_wb_valid,
    output logic              mem_to_wb_we,
    output reg_idx_t          mem_to_wb_rd,
    output logic [DATA_W-1:0] mem_to_wb_data
);

    logic [DATA_W-1:0] mem_result;

    // Stage valid
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_to_mem_valid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (ex_to_mem_valid && mem_allowin) begin
            mem_kind   <= ex_to_mem_kind;
            mem_rd     <= ex_to_mem_rd;
            mem_result <= ex_to_mem_result;
        end
    end

    // Only the addi result is ready this early
    assign mem_fwd_data = mem_result;

    // MEM never holds
    assign mem_to_wb_valid = mem_valid;

    // Stores and reserved kinds write nothing, nor does r0
    assign mem_to_wb_we = ((mem_kind == OP_ADDI) || (mem_kind == OP_LOAD)) &&
                          (mem_rd != '0);
    assign mem_to_wb_rd = mem_rd;

    // Load data arrives the cycle after the request
    assign mem_to_wb_data = (mem_kind == OP_LOAD) ? dmem_rdata : mem_result;

endmodule

/* wb_stage.sv */
// WB stage: last stage register
// Drives the register file write port and the WB forward source

`timescale 1ns/1ps

module wb_stage
    import tiny_backend_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              mem_to_wb_valid,
    input  logic              mem_to_wb_we,
    input  reg_idx_t          mem_to_wb_rd,
    input  logic [DATA_W-1:0] mem_to_wb_data,
    input  logic              wb_allowin,
    output logic              wb_valid,
    output logic              wb_we_out,
    output reg_idx_t          wb_rd,
    output logic [DATA_W-1:0] wb_data
);

    logic wb_we_r;

    // Stage valid
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_to_wb_valid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            wb_we_r <= mem_to_wb_we;
            wb_rd   <= mem_to_wb_rd;
            wb_data <= mem_to_wb_data;
        end
    end

    // Write strobe, also the WB forward enable
    assign wb_we_out = wb_we_r && wb_valid;

endmodule

/* tiny_backend_top.sv */
// Top level of the tiny load/store back end
// Control, EX/MEM/WB stages and the register file

`timescale 1ns/1ps

module tiny_backend_top
    import tiny_backend_pkg::*;
#(
    parameter int unsigned ADDR_W = 10
) (
    input  logic              clk,
    input  logic              reset,
    // Operation input
    input  logic              in_valid,
    output logic              in_allowin,
    input  op_kind_t          in_kind,
    input  reg_idx_t          in_rd,
    input  reg_idx_t          in_rs1,
    input  reg_idx_t          in_rs2,
    input  logic [IMM_W-1:0]  in_imm,
    // Data memory
    output logic              dmem_en,
    output logic              dmem_we,
    output logic [ADDR_W-1:0] dmem_addr,
    output logic [DATA_W-1:0] dmem_wdata,
    input  logic [DATA_W-1:0] dmem_rdata,
    // Retire
    output logic              wb_we,
    output reg_idx_t          wb_addr,
    output logic [DATA_W-1:0] wb_data
);

    // --------------------------------------------------
    // Interconnect
    // --------------------------------------------------

    logic              ex_allowin;
    logic              ex_ready_go;
    logic              mem_allowin;
    logic              wb_allowin;
    logic [1:0]        fwd_sel1;
    logic [1:0]        fwd_sel2;

    logic              ex_valid;
    op_kind_t          ex_kind;
    reg_idx_t          ex_rs1;
    reg_idx_t          ex_rs2;
    logic [DATA_W-1:0] rf_rdata1;
    logic [DATA_W-1:0] rf_rdata2;

    logic              ex_to_mem_valid;
    op_kind_t          ex_to_mem_kind;
    reg_idx_t          ex_to_mem_rd;
    logic [DATA_W-1:0] ex_to_mem_result;

    logic              mem_valid;
    op_kind_t          mem_kind;
    reg_idx_t          mem_rd;
    logic [DATA_W-1:0] mem_fwd_data;
    logic              mem_to_wb_valid;
    logic              mem_to_wb_we;
    reg_idx_t          mem_to_wb_rd;
    logic [DATA_W-1:0] mem_to_wb_data;

    logic              wb_valid;

    // --------------------------------------------------
    // Instances
    // --------------------------------------------------

    pipe_ctrl u_pipe_ctrl (
        .in_valid    (in_valid),
        .ex_valid    (ex_valid),
        .ex_kind     (ex_kind),
        .ex_rs1      (ex_rs1),
        .ex_rs2      (ex_rs2),
        .mem_valid   (mem_valid),
        .mem_kind    (mem_kind),
        .mem_rd      (mem_rd),
        .wb_valid    (wb_valid),
        .wb_we       (wb_we),
        .wb_rd       (wb_addr),
        .in_allowin  (in_allowin),
        .ex_allowin  (ex_allowin),
        .ex_ready_go (ex_ready_go),
        .mem_allowin (mem_allowin),
        .wb_allowin  (wb_allowin),
        .fwd_sel1    (fwd_sel1),
        .fwd_sel2    (fwd_sel2)
    );

    exe_stage #(
        .ADDR_W (ADDR_W)
    ) u_exe_stage (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_kind          (in_kind),
        .in_rd            (in_rd),
        .in_rs1           (in_rs1),
        .in_rs2           (in_rs2),
        .in_imm           (in_imm),
        .ex_allowin       (ex_allowin),
        .ex_ready_go      (ex_ready_go),
        .mem_allowin      (mem_allowin),
        .fwd_sel1         (fwd_sel1),
        .fwd_sel2         (fwd_sel2),
        .rf_rdata1        (rf_rdata1),
        .rf_rdata2        (rf_rdata2),
        .mem_fwd_data     (mem_fwd_data),
        .wb_fwd_data      (wb_data),
        .ex_valid         (ex_valid),
        .ex_kind          (ex_kind),
        .ex_rs1           (ex_rs1),
        .ex_rs2           (ex_rs2),
        .ex_to_mem_valid  (ex_to_mem_valid),
        .ex_to_mem_kind   (ex_to_mem_kind),
        .ex_to_mem_rd     (ex_to_mem_rd),
        .ex_to_mem_result (ex_to_mem_result),
        .dmem_en          (dmem_en),
        .dmem_we          (dmem_we),
        .dmem_addr        (dmem_addr),
        .dmem_wdata       (dmem_wdata)
    );

    mem_stage u_mem_stage (
        .clk              (clk),
        .reset            (reset),
        .ex_to_mem_valid  (ex_to_mem_valid),
        .ex_to_mem_kind   (ex_to_mem_kind),
        .ex_to_mem_rd     (ex_to_mem_rd),
        .ex_to_mem_result (ex_to_mem_result),
        .mem_allowin      (mem_allowin),
        .dmem_rdata       (dmem_rdata),
        .mem_valid        (mem_valid),
        .mem_kind         (mem_kind),
        .mem_rd           (mem_rd),
        .mem_fwd_data     (mem_fwd_data),
        .mem_to_wb_valid  (mem_to_wb_valid),
        .mem_to_wb_we     (mem_to_wb_we),
        .mem_to_wb_rd     (mem_to_wb_rd),
        .mem_to_wb_data   (mem_to_wb_data)
    );

    // WB outputs double as retire port and forward source
    wb_stage u_wb_stage (
        .clk             (clk),
        .reset           (reset),
        .mem_to_wb_valid (mem_to_wb_valid),
        .mem_to_wb_we    (mem_to_wb_we),
        .mem_to_wb_rd    (mem_to_wb_rd),
        .mem_to_wb_data  (mem_to_wb_data),
        .wb_allowin      (wb_allowin),
        .wb_valid        (wb_valid),
        .wb_we_out       (wb_we),
        .wb_rd           (wb_addr),
        .wb_data         (wb_data)
    );

    // Read ports indexed from the EX stage register
    regfile u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (ex_rs1),
        .raddr2 (ex_rs2),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data)
    );

endmodule

/* tiny_backend_tb.sv */
// Testbench for the tiny load/store back end
// LCG stimulus, data memory model, ISA reference model and checks

`timescale 1ns/1ps

module tiny_backend_tb
    import tiny_backend_pkg::*;
();

    // --------------------------------------------------
    // Constants and DUT signals
    // --------------------------------------------------

    localparam int unsigned TB_ADDR_W      = 6;
    localparam int unsigned MEM_WORDS      = 1 << TB_ADDR_W;
    localparam int          NUM_OPS        = 2000;
    localparam int          ACCEPT_TIMEOUT = 16;
    localparam int          DRAIN_TIMEOUT  = 64;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    logic                 in_allowin;
    op_kind_t             in_kind;
    reg_idx_t             in_rd;
    reg_idx_t             in_rs1;
    reg_idx_t             in_rs2;
    logic [IMM_W-1:0]     in_imm;
    logic                 dmem_en;
    logic                 dmem_we;
    logic [TB_ADDR_W-1:0] dmem_addr;
    logic [DATA_W-1:0]    dmem_wdata;
    logic [DATA_W-1:0]    dmem_rdata;
    logic                 wb_we;
    reg_idx_t             wb_addr;
    logic [DATA_W-1:0]    wb_data;

    tiny_backend_top #(
        .ADDR_W (TB_ADDR_W)
    ) u_tiny_backend_top (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_allowin (in_allowin),
        .in_kind    (in_kind),
        .in_rd      (in_rd),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_imm     (in_imm),
        .dmem_en    (dmem_en),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .wb_we      (wb_we),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    // 4 ns period
    initial clk = 1'b0;
    always #2 clk = ~clk;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Initial memory contents, every address bit matters
    function automatic logic [DATA_W-1:0] fill_word(input int unsigned a);
        return (32'h9e37_79b9 * (a + 1)) ^ {a[15:0], ~a[15:0]};
    endfunction

    // True when the operation consumes register r as a source
    function automatic logic reads_reg(input op_kind_t k, input reg_idx_t rs1,
                                       input reg_idx_t rs2, input reg_idx_t r);
        logic hit;
        hit = 1'b0;
        if (k == OP_ADDI || k == OP_LOAD || k == OP_STORE) begin
            hit = (rs1 == r);
        end
        if (k == OP_STORE && rs2 == r) begin
            hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h actual %h", name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // --------------------------------------------------
    // Data memory model, one-cycle read latency
    // --------------------------------------------------

    logic [DATA_W-1:0] dmem [MEM_WORDS];
    logic [DATA_W-1:0] read_latch;

    always @(posedge clk) begin
        if (dmem_en === 1'b1) begin
            if (dmem_we) begin
                dmem[dmem_addr] <= dmem_wdata;
            end else begin
                read_latch <= dmem[dmem_addr];
            end
        end
    end

    // Read data goes out on the falling edge like every other input
    always @(negedge clk) begin
        dmem_rdata <= read_latch;
    end

    // --------------------------------------------------
    // ISA reference model and expectation queues
    // --------------------------------------------------

    logic [DATA_W-1:0] model_regs [NUM_REGS];
    logic [DATA_W-1:0] model_mem [MEM_WORDS];
    logic [31:0]       wb_idx_q[$];
    logic [31:0]       wb_val_q[$];
    logic [31:0]       st_addr_q[$];
    logic [31:0]       st_data_q[$];
    // Word addresses of expected memory reads
    logic [31:0]       ld_addr_q[$];

    int n_loads;
    int n_stores;
    int n_stalls;
    int n_retired;

    task automatic run_model(input op_kind_t k, input reg_idx_t rd, input reg_idx_t rs1,
                             input reg_idx_t rs2, input logic [IMM_W-1:0] imm);
        logic [DATA_W-1:0]    sum;
        logic [TB_ADDR_W-1:0] waddr;
        logic [DATA_W-1:0]    result;
        // Register 0 reads as zero whatever was written
        sum   = model_regs[rs1] + {{(DATA_W-IMM_W){imm[IMM_W-1]}}, imm};
        waddr = sum[TB_ADDR_W+1:2];
        if (k == OP_STORE) begin
            model_mem[waddr] = model_regs[rs2];
            st_addr_q.push_back(32'(waddr));
            st_data_q.push_back(model_regs[rs2]);
            n_stores++;
        end else if (k == OP_ADDI || k == OP_LOAD) begin
            result = (k == OP_LOAD) ? model_mem[waddr] : sum;
            // A load reads memory even when r0 is its target
            if (k == OP_LOAD) begin
                ld_addr_q.push_back(32'(waddr));
                n_loads++;
            end
            if (rd != '0) begin
                model_regs[rd] = result;
                wb_idx_q.push_back(32'(rd));
                wb_val_q.push_back(result);
            end
        end
    endtask

    // --------------------------------------------------
    // Retire and memory request monitor
    // --------------------------------------------------

    always @(posedge clk) begin
        if (!reset && wb_we === 1'b1) begin
            if (wb_idx_q.size() == 0) begin
                abort_run("Register write-back retired with none expected");
            end
            check_value("writeback index", wb_idx_q.pop_front(), 32'(wb_addr));
            check_value("writeback value", wb_val_q.pop_front(), wb_data);
            n_retired++;
        end
        if (!reset && dmem_we === 1'b1) begin
            if (st_addr_q.size() == 0) begin
                abort_run("Memory store issued with none expected");
            end
            check_value("store enable", 32'd1, 32'(dmem_en));
            check_value("store address", st_addr_q.pop_front(), 32'(dmem_addr));
            check_value("store data", st_data_q.pop_front(), dmem_wdata);
        end
        // Any enable without a write must be a load leaving EX
        if (!reset && dmem_en === 1'b1 && dmem_we !== 1'b1) begin
            if (ld_addr_q.size() == 0) begin
                abort_run("Memory read issued with none expected");
            end
            check_value("load address", ld_addr_q.pop_front(), 32'(dmem_addr));
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    logic [31:0] rng;
    int          cycle;
    int          n_acc;
    int          wait_cycles;
    int          drain_cycles;
    logic        have_op;
    logic        expect_stall;
    logic        stall_now;
    logic        prev_load;
    reg_idx_t    prev_rd;
    int          prev_leave;

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_kind    = OP_ADDI;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_imm     = '0;
        dmem_rdata = '0;
        read_latch = '0;
        rng        = 32'hef07_593d;
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Idle after reset, nothing may move
        repeat (4) begin
            @(posedge clk);
            check_value("idle in_allowin", 32'd1, 32'(in_allowin));
            check_value("idle wb_we", 32'd0, 32'(wb_we));
            check_value("idle dmem_en", 32'd0, 32'(dmem_en));
            check_value("idle dmem_we", 32'd0, 32'(dmem_we));
        end

        cycle        = 0;
        n_acc        = 0;
        wait_cycles  = 0;
        have_op      = 1'b0;
        expect_stall = 1'b0;
        prev_load    = 1'b0;
        prev_rd      = '0;
        prev_leave   = -10;
        while (n_acc < NUM_OPS) begin
            @(negedge clk);
            if (!have_op) begin
                rng = lcg_step(rng);
                // About one cycle in eight idles
                if (rng[31:29] == 3'd0) begin
                    in_valid = 1'b0;
                end else begin
                    if (rng[28:25] < 4'd6) begin
                        in_kind = OP_ADDI;
                    end else if (rng[28:25] < 4'd10) begin
                        in_kind = OP_LOAD;
                    end else if (rng[28:25] < 4'd15) begin
                        in_kind = OP_STORE;
                    end else begin
                        in_kind = OP_RSVD;
                    end
                    // Registers 0 to 7 only, so hazards are frequent
                    in_rd    = reg_idx_t'(rng[24:22]);
                    in_rs1   = reg_idx_t'(rng[21:19]);
                    in_rs2   = reg_idx_t'(rng[18:16]);
                    rng      = lcg_step(rng);
                    in_imm   = rng[31:20];
                    in_valid = 1'b1;
                    have_op  = 1'b1;
                end
            end
            @(posedge clk);
            cycle++;
            // Back-pressure only comes from the load-use interlock
            check_value("in_allowin", expect_stall ? 32'd0 : 32'd1, 32'(in_allowin));
            expect_stall = 1'b0;
            if (in_valid && in_allowin) begin
                // Stall when the previous op is a load entering MEM right now
                stall_now = prev_load && (prev_rd != '0) && (prev_leave == cycle) &&
                            reads_reg(in_kind, in_rs1, in_rs2, prev_rd);
                expect_stall = stall_now;
                n_stalls    += stall_now ? 1 : 0;
                prev_load    = (in_kind == OP_LOAD);
                prev_rd      = in_rd;
                prev_leave   = cycle + 1 + (stall_now ? 1 : 0);
                run_model(in_kind, in_rd, in_rs1, in_rs2, in_imm);
                n_acc++;
                have_op     = 1'b0;
                wait_cycles = 0;
            end else if (have_op) begin
                wait_cycles++;
                if (wait_cycles > ACCEPT_TIMEOUT) begin
                    abort_run("Operation was not accepted within the timeout");
                end
            end
        end

        // Drain until every expected write-back and memory request is seen
        @(negedge clk);
        in_valid     = 1'b0;
        drain_cycles = 0;
        while ((wb_idx_q.size() != 0 || st_addr_q.size() != 0 || ld_addr_q.size() != 0) &&
               drain_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            drain_cycles++;
        end
        // A few more cycles to catch stray retirements
        repeat (8) @(posedge clk);

        $display("Accepted %0d ops, %0d loads, %0d stores, %0d stalls, %0d retired",
                 n_acc, n_loads, n_stores, n_stalls, n_retired);
        if (wb_idx_q.size() != 0 || st_addr_q.size() != 0 || ld_addr_q.size() != 0) begin
            abort_run("Pipeline did not drain, expectation queues not empty");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

/* tiny_backend.f */
tiny_backend_pkg.sv
regfile.sv
pipe_ctrl.sv
exe_stage.sv
mem_stage.sv
wb_stage.sv
tiny_backend_top.sv
tiny_backend_tb.sv

/* Bender.yml */
package:
  name: tiny_backend

sources:
  - tiny_backend_pkg.sv
  - regfile.sv
  - pipe_ctrl.sv
  - exe_stage.sv
  - mem_stage.sv
  - wb_stage.sv
  - tiny_backend_top.sv
  - target: test
    files:
      - tiny_backend_tb.sv
